/* Makefile */
TOP := tb_mini_soc

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* source/mini_soc_top.sv */
`timescale 1ns/1ps

`include "soc_consts.svh"

module mini_soc_top (
    input  logic                  clk_i,
    input  logic                  reset_i,

    // Data port
    input  logic                  m0_cyc_i,
    input  logic                  m0_stb_i,
    input  logic                  m0_we_i,
    input  wb_bus_pkg::bus_sel_t  m0_sel_i,
    input  wb_bus_pkg::bus_addr_t m0_addr_i,
    input  wb_bus_pkg::bus_data_t m0_data_i,
    output wb_bus_pkg::bus_data_t m0_data_o,
    output logic                  m0_ack_o,

    // Instruction port
    input  logic                  m1_cyc_i,
    input  logic                  m1_stb_i,
    input  wb_bus_pkg::bus_addr_t m1_addr_i,
    output wb_bus_pkg::bus_data_t m1_data_o,
    output logic                  m1_ack_o,

    // Board pins
    input  logic [`SOC_SW_W-1:0]  switch_i,
    output logic [`SOC_LED_W-1:0] led_o
);
    import wb_bus_pkg::*;

    // Shared bus after arbitration
    logic      bus_cyc;
    logic      bus_stb;
    logic      bus_we;
    bus_sel_t  bus_sel;
    bus_addr_t bus_addr;
    bus_data_t bus_wdata;
    bus_data_t bus_rdata;
    logic      bus_ack;

    // Per-slave strobes and responses
    logic      ram_stb;
    logic      ram_ack;
    bus_data_t ram_rdata;
    logic      gpio_stb;
    logic      gpio_ack;
    bus_data_t gpio_rdata;

    // Read data is broadcast; each port qualifies it with its own ack
    assign m0_data_o = bus_rdata;
    assign m1_data_o = bus_rdata;

    wb_rr_arbiter u_arbiter (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .m0_cyc_i   (m0_cyc_i),
        .m0_stb_i   (m0_stb_i),
        .m0_we_i    (m0_we_i),
        .m0_sel_i   (m0_sel_i),
        .m0_addr_i  (m0_addr_i),
        .m0_data_i  (m0_data_i),
        .m0_ack_o   (m0_ack_o),
        .m1_cyc_i   (m1_cyc_i),
        .m1_stb_i   (m1_stb_i),
        .m1_addr_i  (m1_addr_i),
        .m1_ack_o   (m1_ack_o),
        .bus_cyc_o  (bus_cyc),
        .bus_stb_o  (bus_stb),
        .bus_we_o   (bus_we),
        .bus_sel_o  (bus_sel),
        .bus_addr_o (bus_addr),
        .bus_data_o (bus_wdata),
        .bus_ack_i  (bus_ack)
    );

    wb_addr_decoder u_decoder (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .bus_cyc_i   (bus_cyc),
        .bus_stb_i   (bus_stb),
        .bus_addr_i  (bus_addr),
        .bus_ack_o   (bus_ack),
        .bus_data_o  (bus_rdata),
        .ram_stb_o   (ram_stb),
        .ram_ack_i   (ram_ack),
        .ram_data_i  (ram_rdata),
        .gpio_stb_o  (gpio_stb),
        .gpio_ack_i  (gpio_ack),
        .gpio_data_i (gpio_rdata)
    );

    wb_bram u_ram (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .stb_i   (ram_stb),
        .we_i    (bus_we),
        .sel_i   (bus_sel),
        .addr_i  (bus_addr),
        .data_i  (bus_wdata),
        .data_o  (ram_rdata),
        .ack_o   (ram_ack)
    );

    wb_gpio u_gpio (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .stb_i    (gpio_stb),
        .we_i     (bus_we),
        .sel_i    (bus_sel),
        .addr_i   (bus_addr),
        .data_i   (bus_wdata),
        .data_o   (gpio_rdata),
        .ack_o    (gpio_ack),
        .switch_i (switch_i),
        .led_o    (led_o)
    );

endmodule

/* source/soc_consts.svh */
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Bus widths
`define SOC_ADDR_W      32
`define SOC_DATA_W      32

// RAM depth in words
`define SOC_RAM_WORDS   1024

// Region bases, one region per value of the top address nibble
`define SOC_RAM_BASE    32'h0000_0000
`define SOC_GPIO_BASE   32'h1000_0000
`define SOC_REGION_HI   31
`define SOC_REGION_LO   28

// GPIO pin counts
`define SOC_LED_W       16
`define SOC_SW_W        8

`endif

/* source/soc_map_pkg.sv */
package soc_map_pkg;

    // Target of the granted cycle
    typedef enum logic [1:0] {
        SLV_RAM  = 2'd0,
        SLV_GPIO = 2'd1,
        SLV_NONE = 2'd2
    } slave_sel_t;

    // GPIO register offsets, low address bits only
    typedef logic [3:0] gpio_ofs_t;

    localparam gpio_ofs_t GPIO_LED_OFS = 4'h0;
    localparam gpio_ofs_t GPIO_SW_OFS  = 4'h4;

endpackage

/* source/wb_addr_decoder.sv */
`timescale 1ns/1ps

`include "soc_consts.svh"

module wb_addr_decoder (
    input  logic                  clk_i,
    input  logic                  reset_i,

    // Granted cycle from the arbiter
    input  logic                  bus_cyc_i,
    input  logic                  bus_stb_i,
    input  wb_bus_pkg::bus_addr_t bus_addr_i,
    output logic                  bus_ack_o,
    output wb_bus_pkg::bus_data_t bus_data_o,

    // RAM slave
    output logic                  ram_stb_o,
    input  logic                  ram_ack_i,
    input  wb_bus_pkg::bus_data_t ram_data_i,

    // GPIO slave
    output logic                  gpio_stb_o,
    input  logic                  gpio_ack_i,
    input  wb_bus_pkg::bus_data_t gpio_data_i
);
    import wb_bus_pkg::*;
    import soc_map_pkg::*;

    localparam bus_addr_t RAM_BASE  = `SOC_RAM_BASE;
    localparam bus_addr_t GPIO_BASE = `SOC_GPIO_BASE;

    slave_sel_t target;
    logic       req;
    logic       none_ack_q;

    // Region from the top address nibble
    always_comb begin
        if (bus_addr_i[`SOC_REGION_HI:`SOC_REGION_LO] ==
            RAM_BASE[`SOC_REGION_HI:`SOC_REGION_LO]) begin
            target = SLV_RAM;
        end else if (bus_addr_i[`SOC_REGION_HI:`SOC_REGION_LO] ==
                     GPIO_BASE[`SOC_REGION_HI:`SOC_REGION_LO]) begin
            target = SLV_GPIO;
        end else begin
            target = SLV_NONE;
        end
    end

    assign req        = bus_cyc_i & bus_stb_i;
    assign ram_stb_o  = req & (target == SLV_RAM);
    assign gpio_stb_o = req & (target == SLV_GPIO);

    // Unmapped accesses still complete, so the bus never hangs
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= req && (target == SLV_NONE) && !none_ack_q;
        end
    end

    //////////////////////////////
    // Response mux
    //////////////////////////////

    always_comb begin
        case (target)
            SLV_RAM: begin
                bus_ack_o  = ram_ack_i;
                bus_data_o = ram_data_i;
            end
            SLV_GPIO: begin
                bus_ack_o  = gpio_ack_i;
                bus_data_o = gpio_data_i;
            end
            default: begin
                bus_ack_o  = none_ack_q;
                bus_data_o = '0;
            end
        endcase
    end

endmodule

/* source/wb_bram.sv */
`timescale 1ns/1ps

`include "soc_consts.svh"

module wb_bram (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  wb_bus_pkg::bus_sel_t  sel_i,
    input  wb_bus_pkg::bus_addr_t addr_i,
    input  wb_bus_pkg::bus_data_t data_i,
    output wb_bus_pkg::bus_data_t data_o,
    output logic                  ack_o
);
    import wb_bus_pkg::*;

    localparam int IDX_W = $clog2(`SOC_RAM_WORDS);
    localparam int LANES = `SOC_DATA_W / 8;

    bus_data_t        mem [`SOC_RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             access;

    // Word index, byte offset bits dropped
    assign idx = addr_i[IDX_W+1:2];

    // One access per cycle, taken on the edge that raises ack
    assign access = stb_i & ~ack_o;

    //////////////////////////////
    // Storage and read port
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (access) begin
            if (we_i) begin
                for (int i = 0; i < LANES; i++) begin
                    if (sel_i[i]) begin
                        mem[idx][8*i +: 8] <= data_i[8*i +: 8];
                    end
                end
            end
            data_o <= mem[idx];
        end
    end

    // Ack pulses once per cycle of stb
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

endmodule

/* source/wb_bus_pkg.sv */
`include "soc_consts.svh"

package wb_bus_pkg;

    //////////////////////////////
    // Shared bus payload
    //////////////////////////////

    typedef logic [`SOC_ADDR_W-1:0]   bus_addr_t;
    typedef logic [`SOC_DATA_W-1:0]   bus_data_t;
    typedef logic [`SOC_DATA_W/8-1:0] bus_sel_t;

    //////////////////////////////
    // Master identity
    //////////////////////////////

    typedef logic master_id_t;

    localparam master_id_t MASTER_DATA = 1'b0;
    localparam master_id_t MASTER_INST = 1'b1;

endpackage

/* source/wb_gpio.sv */
`timescale 1ns/1ps

`include "soc_consts.svh"

module wb_gpio (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  wb_bus_pkg::bus_sel_t  sel_i,
    input  wb_bus_pkg::bus_addr_t addr_i,
    input  wb_bus_pkg::bus_data_t data_i,
    output wb_bus_pkg::bus_data_t data_o,
    output logic                  ack_o,
    input  logic [`SOC_SW_W-1:0]  switch_i,
    output logic [`SOC_LED_W-1:0] led_o
);
    import soc_map_pkg::*;

    localparam int LED_LANES = `SOC_LED_W / 8;

    logic [`SOC_SW_W-1:0] sw_meta_q;
    logic [`SOC_SW_W-1:0] sw_sync_q;
    gpio_ofs_t            ofs;
    logic                 access;

    assign ofs    = addr_i[3:0];
    assign access = stb_i & ~ack_o;

    // Two-stage synchroniser for the switches
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sw_meta_q <= '0;
            sw_sync_q <= '0;
        end else begin
            sw_meta_q <= switch_i;
            sw_sync_q <= sw_meta_q;
        end
    end

    //////////////////////////////
    // LED register and ack
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            led_o <= '0;
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
            if (access && we_i && ofs == GPIO_LED_OFS) begin
                for (int i = 0; i < LED_LANES; i++) begin
                    if (sel_i[i]) begin
                        led_o[8*i +: 8] <= data_i[8*i +: 8];
                    end
                end
            end
        end
    end

    // Read data registered alongside ack
    always_ff @(posedge clk_i) begin
        if (access) begin
            case (ofs)
                GPIO_LED_OFS: data_o <= {{(`SOC_DATA_W-`SOC_LED_W){1'b0}}, led_o};
                GPIO_SW_OFS:  data_o <= {{(`SOC_DATA_W-`SOC_SW_W){1'b0}}, sw_sync_q};
                default:      data_o <= '0;
            endcase
        end
    end

endmodule

/* source/wb_rr_arbiter.sv */
`timescale 1ns/1ps

module wb_rr_arbiter (
    input  logic                  clk_i,
    input  logic                  reset_i,

    // Data port
    input  logic                  m0_cyc_i,
    input  logic                  m0_stb_i,
    input  logic                  m0_we_i,
    input  wb_bus_pkg::bus_sel_t  m0_sel_i,
    input  wb_bus_pkg::bus_addr_t m0_addr_i,
    input  wb_bus_pkg::bus_data_t m0_data_i,
    output logic                  m0_ack_o,

    // Instruction port, fetch only
    input  logic                  m1_cyc_i,
    input  logic                  m1_stb_i,
    input  wb_bus_pkg::bus_addr_t m1_addr_i,
    output logic                  m1_ack_o,

    // Shared bus
    output logic                  bus_cyc_o,
    output logic                  bus_stb_o,
    output logic                  bus_we_o,
    output wb_bus_pkg::bus_sel_t  bus_sel_o,
    output wb_bus_pkg::bus_addr_t bus_addr_o,
    output wb_bus_pkg::bus_data_t bus_data_o,
    input  logic                  bus_ack_i
);
    import wb_bus_pkg::*;

    logic       grant_valid_q;
    master_id_t owner_q;
    master_id_t next_owner;
    logic       owner_cyc;
    logic       owner_stb;

    //////////////////////////////
    // Grant state
    //////////////////////////////

    // On a tie the master not granted last wins
    always_comb begin
        if (m0_cyc_i && m1_cyc_i) begin
            next_owner = ~owner_q;
        end else if (m0_cyc_i) begin
            next_owner = MASTER_DATA;
        end else begin
            next_owner = MASTER_INST;
        end
    end

    assign owner_cyc = (owner_q == MASTER_DATA) ? m0_cyc_i : m1_cyc_i;
    assign owner_stb = (owner_q == MASTER_DATA) ? m0_stb_i : m1_stb_i;

    // owner_q keeps the last owner after release, which drives the tie break
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            grant_valid_q <= 1'b0;
            owner_q       <= MASTER_INST;
        end else if (!grant_valid_q) begin
            if (m0_cyc_i || m1_cyc_i) begin
                grant_valid_q <= 1'b1;
                owner_q       <= next_owner;
            end
        end else if (!owner_cyc) begin
            grant_valid_q <= 1'b0;
        end
    end

    //////////////////////////////
    // Request routing
    //////////////////////////////

    assign bus_cyc_o = grant_valid_q & owner_cyc;
    assign bus_stb_o = grant_valid_q & owner_stb;

    always_comb begin
        if (owner_q == MASTER_DATA) begin
            bus_we_o   = m0_we_i;
            bus_sel_o  = m0_sel_i;
            bus_addr_o = m0_addr_i;
            bus_data_o = m0_data_i;
        end else begin
            // Fetches are full-word reads
            bus_we_o   = 1'b0;
            bus_sel_o  = '1;
            bus_addr_o = m1_addr_i;
            bus_data_o = '0;
        end
    end

    // Ack goes back to the owner only
    assign m0_ack_o = bus_ack_i & grant_valid_q & m0_cyc_i & (owner_q == MASTER_DATA);
    assign m1_ack_o = bus_ack_i & grant_valid_q & m1_cyc_i & (owner_q == MASTER_INST);

endmodule

/* src.f */
+incdir+source
source/wb_bus_pkg.sv
source/soc_map_pkg.sv
source/wb_rr_arbiter.sv
source/wb_addr_decoder.sv
source/wb_bram.sv
source/wb_gpio.sv
source/mini_soc_top.sv
tb/mini_soc_properties.sv
tb/tb_mini_soc.sv

/* tb/bus_trace.txt */
# columns: op master addr sel data expect, numbers in hex
# DUAL_M0 stages the m0 read of a tie, DUAL_M1 starts both and names the first winner
WR 0 00000010 f 12345678 0
RD 0 00000010 f 0 12345678
WR 0 00000010 2 0000ab00 0
RD 0 00000010 f 0 1234ab78
WR 0 00000020 f cafef00d 0
WR 0 00000024 f 0badc0de 0
RD 1 00000020 f 0 cafef00d
RD 1 00000024 f 0 0badc0de
WR 0 10000000 3 0000a5c3 0
LED 0 0 0 0 a5c3
RD 0 10000000 f 0 0000a5c3
WR 0 10000000 1 00000011 0
LED 0 0 0 0 a511
SW 0 0 0 5a 0
RD 0 10000004 f 0 0000005a
RD 0 20000000 f 0 0
WR 0 20000010 f ffffffff 0
RD 0 00000010 f 0 1234ab78
LED 0 0 0 0 a511
RESET 0 0 0 0 0
LED 0 0 0 0 0
DUAL_M0 0 00000020 f 0 cafef00d
DUAL_M1 0 00000024 f 0 0badc0de
RD 0 10000000 f 0 0
DUAL_M0 0 00000010 f 0 1234ab78
DUAL_M1 1 00000024 f 0 0badc0de

/* tb/mini_soc_properties.sv */
`timescale 1ns/1ps

module mini_soc_properties (
    input logic clk_i,
    input logic reset_i,
    input logic m0_cyc_i,
    input logic m1_cyc_i,
    input logic m0_ack_i,
    input logic m1_ack_i,
    input logic grant_valid_i,
    input logic owner_i
);
    logic owner_cyc;

    assign owner_cyc = owner_i ? m1_cyc_i : m0_cyc_i;

    // Only the owner ever sees ack
    one_ack_a: assert property (@(posedge clk_i) disable iff (reset_i)
        !(m0_ack_i && m1_ack_i))
        else $error("Both masters acked in one cycle");

    ack_needs_cyc_a: assert property (@(posedge clk_i) disable iff (reset_i)
        !(m0_ack_i && !m0_cyc_i) && !(m1_ack_i && !m1_cyc_i))
        else $error("Ack given to a master with cyc low");

    // Owner keeps the bus for its whole cycle
    grant_held_a: assert property (@(posedge clk_i) disable iff (reset_i)
        (grant_valid_i && owner_cyc) |=> (grant_valid_i && $stable(owner_i)))
        else $error("Grant changed while the owner held cyc");

endmodule

bind wb_rr_arbiter mini_soc_properties u_props (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .m0_cyc_i      (m0_cyc_i),
    .m1_cyc_i      (m1_cyc_i),
    .m0_ack_i      (m0_ack_o),
    .m1_ack_i      (m1_ack_o),
    .grant_valid_i (grant_valid_q),
    .owner_i       (owner_q)
);

/* tb/tb_mini_soc.sv */
`timescale 1ns/1ps

`include "soc_consts.svh"

module tb_mini_soc;

    // Operation codes as $fscanf packs them, right aligned
    localparam logic [63:0] OP_COMMENT = {56'h0, "#"};
    localparam logic [63:0] OP_WR      = {48'h0, "WR"};
    localparam logic [63:0] OP_RD      = {48'h0, "RD"};
    localparam logic [63:0] OP_LED     = {40'h0, "LED"};
    localparam logic [63:0] OP_SW      = {48'h0, "SW"};
    localparam logic [63:0] OP_RESET   = {24'h0, "RESET"};
    localparam logic [63:0] OP_DUAL_M0 = {8'h0, "DUAL_M0"};
    localparam logic [63:0] OP_DUAL_M1 = {8'h0, "DUAL_M1"};

    // Grant plus slave on an idle bus, and the loser of a tie
    localparam int IDLE_LATENCY  = 2;
    localparam int LOSER_LATENCY = 5;

    logic                  clk;
    logic                  reset;
    logic                  m0_cyc;
    logic                  m0_stb;
    logic                  m0_we;
    logic [3:0]            m0_sel;
    logic [31:0]           m0_addr;
    logic [31:0]           m0_wdata;
    logic [31:0]           m0_rdata;
    logic                  m0_ack;
    logic                  m1_cyc;
    logic                  m1_stb;
    logic [31:0]           m1_addr;
    logic [31:0]           m1_rdata;
    logic                  m1_ack;
    logic [`SOC_SW_W-1:0]  switch;
    logic [`SOC_LED_W-1:0] led;

    int cycle_count;
    int cycle_limit;

    // Trace records
    logic [63:0] rec_op[$];
    logic        rec_master[$];
    logic [31:0] rec_addr[$];
    logic [3:0]  rec_sel[$];
    logic [31:0] rec_data[$];
    logic [31:0] rec_expect[$];

    // m0 half of a tie, held until the m1 half arrives
    logic [31:0] tie_m0_addr;
    logic [31:0] tie_m0_expect;

    mini_soc_top u_dut (
        .clk_i     (clk),
        .reset_i   (reset),
        .m0_cyc_i  (m0_cyc),
        .m0_stb_i  (m0_stb),
        .m0_we_i   (m0_we),
        .m0_sel_i  (m0_sel),
        .m0_addr_i (m0_addr),
        .m0_data_i (m0_wdata),
        .m0_data_o (m0_rdata),
        .m0_ack_o  (m0_ack),
        .m1_cyc_i  (m1_cyc),
        .m1_stb_i  (m1_stb),
        .m1_addr_i (m1_addr),
        .m1_data_o (m1_rdata),
        .m1_ack_o  (m1_ack),
        .switch_i  (switch),
        .led_o     (led)
    );

    always #5 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            abort_run("Run did not finish within its cycle limit");
        end
    end

    //////////////////////////////
    // Reporting
    //////////////////////////////

    task automatic abort_run(input string why);
        begin
            $display("%s", why);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Run aborted");
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        begin
            if (expected !== actual) begin
                $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
                $display("TEST RESULT: FAIL");
                $fatal(1, "Value mismatch in %s", name);
            end
        end
    endtask

    //////////////////////////////
    // Trace loading
    //////////////////////////////

    task automatic load_trace();
        int             fd;
        int             code;
        logic           done;
        logic [63:0]    op;
        logic [31:0]    f_master;
        logic [31:0]    f_addr;
        logic [31:0]    f_sel;
        logic [31:0]    f_data;
        logic [31:0]    f_expect;
        logic [2047:0]  skip_line;
        begin
            fd = $fopen("tb/bus_trace.txt", "r");
            if (fd == 0) begin
                abort_run("Could not open tb/bus_trace.txt");
            end
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, "%s", op);
                if (code != 1) begin
                    done = 1'b1;
                end else if (op == OP_COMMENT) begin
                    code = $fgets(skip_line, fd);
                end else begin
                    code = $fscanf(fd, "%h %h %h %h %h",
                                   f_master, f_addr, f_sel, f_data, f_expect);
                    if (code != 5) begin
                        abort_run("Malformed line in the trace file");
                    end
                    rec_op.push_back(op);
                    rec_master.push_back(f_master[0]);
                    rec_addr.push_back(f_addr);
                    rec_sel.push_back(f_sel[3:0]);
                    rec_data.push_back(f_data);
                    rec_expect.push_back(f_expect);
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////
    // Bus operations
    //////////////////////////////

    task automatic idle_masters();
        begin
            m0_cyc   = 1'b0;
            m0_stb   = 1'b0;
            m0_we    = 1'b0;
            m0_sel   = 4'h0;
            m0_addr  = 32'h0;
            m0_wdata = 32'h0;
            m1_cyc   = 1'b0;
            m1_stb   = 1'b0;
            m1_addr  = 32'h0;
        end
    endtask

    task automatic apply_reset();
        begin
            reset = 1'b1;
            repeat (3) @(negedge clk);
            reset = 1'b0;
        end
    endtask

    // One cycle on an idle bus, entered and left on a falling edge
    task automatic bus_access(input int idx, input logic master, input logic we,
                              input logic [3:0] sel, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [31:0] expect_rd);
        int          cycles;
        logic        got_ack;
        logic [31:0] rdata;
        begin
            cycles  = 0;
            got_ack = 1'b0;
            if (!master) begin
                m0_cyc   = 1'b1;
                m0_stb   = 1'b1;
                m0_we    = we;
                m0_sel   = sel;
                m0_addr  = addr;
                m0_wdata = wdata;
            end else begin
                m1_cyc  = 1'b1;
                m1_stb  = 1'b1;
                m1_addr = addr;
            end
            while (!got_ack) begin
                @(negedge clk);
                cycles++;
                got_ack = master ? m1_ack : m0_ack;
            end
            rdata = master ? m1_rdata : m0_rdata;
            idle_masters();
            check_value($sformatf("rec %0d latency", idx), IDLE_LATENCY, cycles);
            if (!we) begin
                check_value($sformatf("rec %0d read data", idx), expect_rd, rdata);
            end
            // Let the arbiter release before the next request
            @(negedge clk);
        end
    endtask

    // Both masters raise a read in the same cycle
    task automatic tie_access(input int idx, input logic first_exp,
                              input logic [31:0] m1_addr_v, input logic [31:0] m1_expect);
        int          cycles;
        int          m0_cycles;
        int          m1_cycles;
        logic        m0_done;
        logic        m1_done;
        logic        first_id;
        logic [31:0] m0_got;
        logic [31:0] m1_got;
        begin
            cycles   = 0;
            m0_done  = 1'b0;
            m1_done  = 1'b0;
            first_id = 1'b0;
            m0_cyc   = 1'b1;
            m0_stb   = 1'b1;
            m0_we    = 1'b0;
            m0_sel   = 4'hf;
            m0_addr  = tie_m0_addr;
            m1_cyc   = 1'b1;
            m1_stb   = 1'b1;
            m1_addr  = m1_addr_v;
            while (!(m0_done && m1_done)) begin
                @(negedge clk);
                cycles++;
                if (m0_ack && m1_ack) begin
                    abort_run("Both masters were acked in the same cycle");
                end
                if (m0_cyc && m0_ack) begin
                    if (!m1_done) begin
                        first_id = 1'b0;
                    end
                    m0_done   = 1'b1;
                    m0_cycles = cycles;
                    m0_got    = m0_rdata;
                    m0_cyc    = 1'b0;
                    m0_stb    = 1'b0;
                end
                if (m1_cyc && m1_ack) begin
                    if (!m0_done) begin
                        first_id = 1'b1;
                    end
                    m1_done   = 1'b1;
                    m1_cycles = cycles;
                    m1_got    = m1_rdata;
                    m1_cyc    = 1'b0;
                    m1_stb    = 1'b0;
                end
            end
            idle_masters();
            check_value($sformatf("rec %0d first grant", idx), {31'b0, first_exp},
                        {31'b0, first_id});
            check_value($sformatf("rec %0d winner latency", idx), IDLE_LATENCY,
                        first_id ? m1_cycles : m0_cycles);
            check_value($sformatf("rec %0d loser latency", idx), LOSER_LATENCY,
                        first_id ? m0_cycles : m1_cycles);
            check_value($sformatf("rec %0d m0 data", idx), tie_m0_expect, m0_got);
            check_value($sformatf("rec %0d m1 data", idx), m1_expect, m1_got);
            @(negedge clk);
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        switch        = '0;
        cycle_count   = 0;
        cycle_limit   = 50;
        tie_m0_addr   = 32'h0;
        tie_m0_expect = 32'h0;
        idle_masters();
        load_trace();
        cycle_limit = 20 * rec_op.size() + 50;
        apply_reset();

        for (int i = 0; i < rec_op.size(); i++) begin
            if (rec_op[i] == OP_WR) begin
                if (rec_master[i]) begin
                    abort_run("Trace asks the instruction port to write");
                end
                bus_access(i, 1'b0, 1'b1, rec_sel[i], rec_addr[i], rec_data[i], 32'h0);
            end else if (rec_op[i] == OP_RD) begin
                bus_access(i, rec_master[i], 1'b0, rec_sel[i], rec_addr[i], 32'h0,
                           rec_expect[i]);
            end else if (rec_op[i] == OP_LED) begin
                check_value($sformatf("rec %0d led", i), rec_expect[i],
                            {{(32-`SOC_LED_W){1'b0}}, led});
            end else if (rec_op[i] == OP_SW) begin
                switch = rec_data[i][`SOC_SW_W-1:0];
                repeat (3) @(negedge clk);
            end else if (rec_op[i] == OP_RESET) begin
                apply_reset();
            end else if (rec_op[i] == OP_DUAL_M0) begin
                tie_m0_addr   = rec_addr[i];
                tie_m0_expect = rec_expect[i];
            end else if (rec_op[i] == OP_DUAL_M1) begin
                tie_access(i, rec_master[i], rec_addr[i], rec_expect[i]);
            end else begin
                abort_run("Unknown operation in the trace file");
            end
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
